/* hdl/vm_cfg.svh */
`ifndef VM_CFG_SVH
`define VM_CFG_SVH

// number of translation requesters
// the requester id is 2 bits wide, so this stays at or below 4
`define VM_NUM_RQS 3

// table memory size in 32-bit words (16 KiB)
`define VM_PT_WORDS 4096

// physical byte address falls inside the table memory
`define VM_IS_LEGAL_ADDR(addr) ((addr) < (4 * `VM_PT_WORDS))

`endif

/* hdl/vmTypes.sv */
`include "vm_cfg.svh"

package vmTypes;

    // Sv32 addresses
    typedef logic [31:0] vAddr;
    typedef logic [31:0] pAddr;

    // page-table entry and its fields
    typedef logic [31:0] pte;
    typedef logic [21:0] ppn;
    typedef logic [19:0] vpn;
    typedef logic [2:0] rwxBits;

    // word index into the table memory
    typedef logic [$clog2(`VM_PT_WORDS)-1:0] ptIndex;

    // bit positions inside a pte
    localparam int PteV = 0;
    localparam int PteR = 1;
    localparam int PteW = 2;
    localparam int PteX = 3;
    localparam int PteU = 4;
    localparam int PteG = 5;
    localparam int PteA = 6;
    localparam int PteD = 7;
    localparam int PtePpnLsb = 10;

endpackage

/* hdl/walkTypes.sv */
package walkTypes;

    // which requester a walk belongs to
    typedef logic [1:0] rqId;

    // walker FSM
    typedef enum logic [0:0] {
        IDLE,
        WAIT_FOR_LOAD
    } walkState;

    // current table level, 1 is the root level
    typedef logic walkLevel;

endpackage

/* hdl/ptLoadIf.sv */
interface ptLoadIf;
    import vmTypes::*;

    // walker to load port
    logic ldValid;
    pAddr ldAddr;
    logic stall;

    // load port to memory
    logic memRdEn;
    ptIndex memRdAddr;

    // memory back to walker
    logic resValid;
    pte resData;

    modport walker (output ldValid, output ldAddr, input stall, input resValid, input resData);

    modport port (input ldValid, input ldAddr, output stall, output memRdEn, output memRdAddr);

    modport mem (input memRdEn, input memRdAddr, output resValid, output resData);

endinterface

/* hdl/pageWalker.sv */
`include "vm_cfg.svh"

module pageWalker (
    input logic clk,
    input logic rst,

    input logic rqValid [`VM_NUM_RQS-1:0],
    input vmTypes::vAddr rqAddr [`VM_NUM_RQS-1:0],
    input vmTypes::ppn rqRootPpn [`VM_NUM_RQS-1:0],

    output logic resValid,
    output logic resBusy,
    output walkTypes::rqId resRqId,
    output vmTypes::vpn resVpn,
    output vmTypes::ppn resPpn,
    output vmTypes::rwxBits resRwx,
    output logic resPageFault,
    output logic resSuperPage,
    output logic resGlobal,
    output logic resUser,

    ptLoadIf.walker ld
);
    import vmTypes::*;
    import walkTypes::*;

    walkState state;
    walkLevel level;
    vAddr walkVAddr;

    logic pickAny;
    rqId pickId;

    pte entry;
    pAddr nextAddr;
    logic isPointer;
    logic fault;
    logic superPage;
    rwxBits rwx;

    // lowest index wins
    always_comb begin
        pickAny = 1'b0;
        pickId = '0;
        for (int i = `VM_NUM_RQS - 1; i >= 0; i--) begin
            if (rqValid[i]) begin
                pickAny = 1'b1;
                pickId = rqId'(i);
            end
        end
    end

    assign entry = ld.resData;

    // V set with RWX clear points to the next level
    assign isPointer = entry[PteV] && (entry[PteX:PteR] == 3'b000) && (entry[31:30] == 2'b00);
    assign nextAddr = {entry[29:10], walkVAddr[21:12], 2'b00};
    assign superPage = (level == 1'b1);

    always_comb begin
        fault = 1'b0;
        if (!entry[PteV] || !entry[PteA]) begin
            fault = 1'b1;
        end
        // a superpage must be aligned to 4 MiB
        if (superPage && (entry[19:PtePpnLsb] != '0)) begin
            fault = 1'b1;
        end
        case (entry[PteX:PteR])
            3'b000, 3'b010, 3'b110: fault = 1'b1;
            default: ;
        endcase
        // write only once the page is dirty
        rwx = fault ? '0 : {entry[PteR], entry[PteW] && entry[PteD], entry[PteX]};
    end

    always_ff @(posedge clk) begin
        resValid <= 1'b0;
        if (rst) begin
            state <= IDLE;
            resBusy <= 1'b0;
            ld.ldValid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // the finished requester still shows rqValid during its result cycle
                    if (pickAny && !resValid) begin
                        state <= WAIT_FOR_LOAD;
                        level <= 1'b1;
                        walkVAddr <= rqAddr[pickId];
                        resRqId <= pickId;
                        resBusy <= 1'b1;
                        ld.ldValid <= 1'b1;
                        ld.ldAddr <= {rqRootPpn[pickId][19:0], rqAddr[pickId][31:22], 2'b00};
                    end
                end

                WAIT_FOR_LOAD: begin
                    if (ld.ldValid) begin
                        // load port took it
                        if (!ld.stall) begin
                            ld.ldValid <= 1'b0;
                        end
                    end else if (ld.resValid) begin
                        if (isPointer && level && `VM_IS_LEGAL_ADDR(nextAddr)) begin
                            level <= 1'b0;
                            ld.ldValid <= 1'b1;
                            ld.ldAddr <= nextAddr;
                        end else begin
                            state <= IDLE;
                            resBusy <= 1'b0;
                            resValid <= 1'b1;
                            resVpn <= walkVAddr[31:12];
                            resPpn <= entry[31:PtePpnLsb];
                            resRwx <= rwx;
                            resPageFault <= fault;
                            resSuperPage <= superPage;
                            resGlobal <= !fault && entry[PteG];
                            resUser <= !fault && entry[PteU];
                        end
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* hdl/ptLoadPort.sv */
module ptLoadPort (
    input logic clk,
    input logic rst,
    input logic memBusy,
    ptLoadIf.port ld
);
    import vmTypes::*;

    logic full;
    pAddr heldAddr;
    logic take;
    logic issue;

    // hold the walker off only while the entry cannot drain
    assign ld.stall = full && memBusy;
    assign take = ld.ldValid && !ld.stall;
    assign issue = full && !memBusy;

    assign ld.memRdEn = issue;
    // byte address to word index
    assign ld.memRdAddr = ptIndex'(heldAddr >> 2);

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (issue) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            heldAddr <= ld.ldAddr;
        end
    end

endmodule

/* hdl/ptMemory.sv */
`include "vm_cfg.svh"

module ptMemory (
    input logic clk,
    input logic wrEn,
    input vmTypes::ptIndex wrAddr,
    input vmTypes::pte wrData,
    ptLoadIf.mem ld
);
    import vmTypes::*;

    pte ram [`VM_PT_WORDS];

    // address stage
    logic rdValidQ;
    ptIndex rdAddrQ;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            ram[wrAddr] <= wrData;
        end
    end

    // two reads can be in flight, one per stage
    always_ff @(posedge clk) begin
        rdValidQ <= ld.memRdEn;
        rdAddrQ <= ld.memRdAddr;
        ld.resValid <= rdValidQ;
        ld.resData <= ram[rdAddrQ];
    end

endmodule

/* hdl/vmWalkTop.sv */
`include "vm_cfg.svh"

module vmWalkTop (
    input logic clk,
    input logic rst,

    input logic rqValid [`VM_NUM_RQS-1:0],
    input vmTypes::vAddr rqAddr [`VM_NUM_RQS-1:0],
    input vmTypes::ppn rqRootPpn [`VM_NUM_RQS-1:0],

    output logic resValid,
    output logic resBusy,
    output walkTypes::rqId resRqId,
    output vmTypes::vpn resVpn,
    output vmTypes::ppn resPpn,
    output vmTypes::rwxBits resRwx,
    output logic resPageFault,
    output logic resSuperPage,
    output logic resGlobal,
    output logic resUser,

    input logic memBusy,

    // table fill port
    input logic tblWrEn,
    input vmTypes::ptIndex tblWrAddr,
    input vmTypes::pte tblWrData
);

    ptLoadIf ldBus ();

    pageWalker pageWalker_i (
        .clk(clk),
        .rst(rst),
        .rqValid(rqValid),
        .rqAddr(rqAddr),
        .rqRootPpn(rqRootPpn),
        .resValid(resValid),
        .resBusy(resBusy),
        .resRqId(resRqId),
        .resVpn(resVpn),
        .resPpn(resPpn),
        .resRwx(resRwx),
        .resPageFault(resPageFault),
        .resSuperPage(resSuperPage),
        .resGlobal(resGlobal),
        .resUser(resUser),
        .ld(ldBus.walker)
    );

    ptLoadPort ptLoadPort_i (
        .clk(clk),
        .rst(rst),
        .memBusy(memBusy),
        .ld(ldBus.port)
    );

    ptMemory ptMemory_i (
        .clk(clk),
        .wrEn(tblWrEn),
        .wrAddr(tblWrAddr),
        .wrData(tblWrData),
        .ld(ldBus.mem)
    );

endmodule

/* verification/vmWalk_properties.sv */
module vmWalk_properties (
    input logic clk,
    input logic rst,
    input logic resValid,
    input logic resBusy,
    input logic ldValid,
    input logic stall
);

    // result is a one-cycle pulse
    assert property (@(posedge clk) disable iff (rst) resValid |=> !resValid)
        else $error("resValid stayed high for two cycles");

    assert property (@(posedge clk) disable iff (rst) !(resValid && resBusy))
        else $error("resValid and resBusy high together");

    // a stalled load is held until the port takes it
    assert property (@(posedge clk) disable iff (rst) (ldValid && stall) |=> ldValid)
        else $error("ldValid dropped while stall was high");

    assert property (@(posedge clk) disable iff (rst) resValid |-> $past(resBusy))
        else $error("resValid without resBusy in the cycle before");

endmodule

bind pageWalker vmWalk_properties vmWalkProps_i (
    .clk(clk),
    .rst(rst),
    .resValid(resValid),
    .resBusy(resBusy),
    .ldValid(ld.ldValid),
    .stall(ld.stall)
);

/* verification/vmWalkTb.sv */
`include "vm_cfg.svh"

module vmWalkTb;
    import vmTypes::*;
    import walkTypes::*;

    localparam int NumRqs = `VM_NUM_RQS;
    localparam int SingleRounds = 60;
    localparam int MultiRounds = 40;
    localparam int NumWalks = SingleRounds + MultiRounds * NumRqs;
    // reset and table fill, then at most 64 cycles for each walk
    localparam int CycleLimit = 16 + `VM_PT_WORDS + 64 * NumWalks;

    logic clk;
    logic rst;
    logic rqValid [NumRqs-1:0];
    vAddr rqAddr [NumRqs-1:0];
    ppn rqRootPpn [NumRqs-1:0];
    logic resValid;
    logic resBusy;
    rqId resRqId;
    vpn resVpn;
    ppn resPpn;
    rwxBits resRwx;
    logic resPageFault;
    logic resSuperPage;
    logic resGlobal;
    logic resUser;
    logic memBusy;
    logic tblWrEn;
    ptIndex tblWrAddr;
    pte tblWrData;

    pte tbl [`VM_PT_WORDS];
    logic [31:0] seed;
    logic [31:0] busySeed;
    int cycles;
    int errors;
    int walkCount;
    int resultCount [NumRqs];
    int expCount [NumRqs];

    vmWalkTop vmWalkTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // upper halves of two LCG steps
    function automatic logic [31:0] rand32();
        logic [31:0] a;
        a = lcgStep(seed);
        seed = lcgStep(a);
        return {a[31:16], seed[31:16]};
    endfunction

    // kinds 0..5 are pointers, kind 5 points outside the table; the rest are leaves
    function automatic pte makeEntry(input logic [31:0] r, input logic [3:0] kind);
        pte e;
        e = r;
        if (kind <= 4'd5) begin
            e[3:0] = 4'b0001;
            e[31:12] = '0;
            e[20] = (kind == 4'd5);
        end else begin
            e[PteV] = e[PteV] || (kind != 4'd6);
            e[PteA] = e[PteA] || (kind != 4'd7);
            // aligned superpage candidates
            if (kind >= 4'd12) begin
                e[19:10] = '0;
            end
        end
        return e;
    endfunction

    task automatic modelWalk(input ppn root, input vAddr va, output ppn oPpn,
                             output rwxBits oRwx, output logic [3:0] oFlags);
        logic [33:0] addr;
        pte e;
        logic atLevel1;
        logic fault;
        addr = {root, va[31:22], 2'b00};
        e = tbl[addr[13:2]];
        atLevel1 = 1'b1;
        addr = {e[31:10], va[21:12], 2'b00};
        if (e[PteV] && e[3:1] == 3'b000 && e[31:30] == 2'b00
                && addr < 34'(4 * `VM_PT_WORDS)) begin
            e = tbl[addr[13:2]];
            atLevel1 = 1'b0;
        end
        // no permission at all, or write without read
        fault = !e[PteV] || !e[PteA] || (e[3:1] == 3'b000) || (e[PteW] && !e[PteR]);
        fault = fault || (atLevel1 && e[19:10] != 10'd0);
        oPpn = e[31:10];
        oRwx = fault ? 3'b000 : {e[PteR], e[PteW] && e[PteD], e[PteX]};
        oFlags = {fault, atLevel1, e[PteG] && !fault, e[PteU] && !fault};
    endtask

    task automatic checkPpn(input string sig, input ppn got, input ppn exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", sig, got, exp);
        end
    endtask

    task automatic compareRwx(input string sig, input rwxBits got, input rwxBits exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", sig, got, exp);
        end
    endtask

    task automatic expectRqId(input string sig, input rqId got, input rqId exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", sig, got, exp);
        end
    endtask

    task automatic matchVpn(input string sig, input vpn got, input vpn exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", sig, got, exp);
        end
    endtask

    task automatic verifyFlags(input string sig, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", sig, got, exp);
        end
    endtask

    task automatic confirmBusy(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", sig, got, exp);
        end
    endtask

    task automatic fillTable();
        logic [31:0] r;
        for (int i = 0; i < `VM_PT_WORDS; i++) begin
            r = rand32();
            tbl[i] = makeEntry(rand32(), r[31:28]);
            tblWrEn <= 1'b1;
            tblWrAddr <= ptIndex'(i);
            tblWrData <= tbl[i];
            @(posedge clk);
        end
        tblWrEn <= 1'b0;
        @(posedge clk);
    endtask

    // resBusy covers the walk and drops in the result cycle
    task automatic waitResult();
        logic busyBefore;
        busyBefore = 1'b0;
        do begin
            @(posedge clk);
            if (!resValid) begin
                busyBefore = resBusy;
            end
        end while (!resValid);
        confirmBusy("resBusy before resValid", busyBefore, 1'b1);
        confirmBusy("resBusy", resBusy, 1'b0);
    endtask

    task automatic runTest(input string name, input int rounds, input logic allActive);
        int startErrors;
        int faults;
        int pick;
        vAddr va;
        ppn root;
        logic [31:0] r;
        logic active [NumRqs];
        vpn expVpn [NumRqs];
        ppn expPpn [NumRqs];
        rwxBits expRwx [NumRqs];
        logic [3:0] expFlags [NumRqs];
        startErrors = errors;
        faults = 0;
        for (int n = 0; n < rounds; n++) begin
            pick = int'(rand32() % NumRqs);
            for (int i = 0; i < NumRqs; i++) begin
                active[i] = allActive || (i == pick);
                if (active[i]) begin
                    r = rand32();
                    va = rand32();
                    // roots stay inside the 16 KiB table
                    root = {20'd0, r[1:0]};
                    rqAddr[i] <= va;
                    rqRootPpn[i] <= root;
                    rqValid[i] <= 1'b1;
                    modelWalk(root, va, expPpn[i], expRwx[i], expFlags[i]);
                    expVpn[i] = va[31:12];
                    expCount[i]++;
                end
            end
            // lowest index is served first
            for (int i = 0; i < NumRqs; i++) begin
                if (active[i]) begin
                    waitResult();
                    expectRqId("resRqId", resRqId, rqId'(i));
                    matchVpn("resVpn", resVpn, expVpn[i]);
                    checkPpn("resPpn", resPpn, expPpn[i]);
                    compareRwx("resRwx", resRwx, expRwx[i]);
                    verifyFlags("resPageFault,resSuperPage,resGlobal,resUser",
                                {resPageFault, resSuperPage, resGlobal, resUser}, expFlags[i]);
                    rqValid[i] <= 1'b0;
                    if (expFlags[i][3]) begin
                        faults++;
                    end
                    walkCount++;
                end
            end
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        for (int i = 0; i < NumRqs; i++) begin
            if (resultCount[i] != expCount[i]) begin
                errors++;
                $display("requester %0d returned %0d results where %0d were expected",
                         i, resultCount[i], expCount[i]);
            end
        end
        $display("%s: %0d rounds, %0d faults, %0d errors", name, rounds, faults,
                 errors - startErrors);
    endtask

    // results per requester, to catch drops and duplicates
    initial begin
        for (int i = 0; i < NumRqs; i++) begin
            resultCount[i] = 0;
        end
        forever begin
            @(posedge clk);
            if (resValid && int'(resRqId) < NumRqs) begin
                resultCount[resRqId]++;
            end
        end
    end

    // back-pressure on its own sequence
    initial begin
        busySeed = ~32'd15;
        memBusy = 1'b0;
        forever begin
            @(posedge clk);
            busySeed = lcgStep(busySeed);
            memBusy <= busySeed[30];
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        seed = 32'd15;
        errors = 0;
        walkCount = 0;
        rst = 1'b1;
        tblWrEn = 1'b0;
        tblWrAddr = '0;
        tblWrData = '0;
        for (int i = 0; i < NumRqs; i++) begin
            rqValid[i] = 1'b0;
            rqAddr[i] = '0;
            rqRootPpn[i] = '0;
            expCount[i] = 0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        fillTable();
        runTest("single requester walks", SingleRounds, 1'b0);
        runTest("three requesters together", MultiRounds, 1'b1);
        $display("%0d walks, %0d errors", walkCount, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+hdl
hdl/vmTypes.sv
hdl/walkTypes.sv
hdl/ptLoadIf.sv
hdl/pageWalker.sv
hdl/ptLoadPort.sv
hdl/ptMemory.sv
hdl/vmWalkTop.sv
verification/vmWalk_properties.sv
verification/vmWalkTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= vmWalkTb
FILELIST ?= tb.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
